// File: hw/id_pkg.sv
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] regaddr_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [6:0]            funct7_t;

    // major opcodes, RV32I base set only
    localparam opcode_t OP          = 7'b0110011;
    localparam opcode_t OP_IMM      = 7'b0010011;
    localparam opcode_t OP_LUI      = 7'b0110111;
    localparam opcode_t OP_AUIPC    = 7'b0010111;
    localparam opcode_t OP_JAL      = 7'b1101111;
    localparam opcode_t OP_JALR     = 7'b1100111;
    localparam opcode_t OP_BRANCH   = 7'b1100011;
    localparam opcode_t OP_LOAD     = 7'b0000011;
    localparam opcode_t OP_STORE    = 7'b0100011;
    localparam opcode_t OP_MISC_MEM = 7'b0001111;

    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;
    localparam funct3_t F3_BLT     = 3'b100;
    localparam funct3_t F3_BGE     = 3'b101;
    localparam funct3_t F3_BLTU    = 3'b110;
    localparam funct3_t F3_BGEU    = 3'b111;

    // {f7[0], f7[5], f3} or {2'b00, f3}
    typedef logic [4:0] alu_mode_t;
    localparam alu_mode_t ALU_ADD   = 5'b00000;
    localparam alu_mode_t ALU_COPY1 = 5'b11111;
    localparam alu_mode_t ALU_X     = 5'b00000;

    typedef enum logic [1:0] {
        ALU_OP1_X, ALU_OP1_RS1, ALU_OP1_IMMU
    } alu_op1_sel_t;

    typedef enum logic [2:0] {
        ALU_OP2_X, ALU_OP2_RS2, ALU_OP2_IMMI, ALU_OP2_IMMS, ALU_OP2_PC
    } alu_op2_sel_t;

    typedef enum logic [1:0] {
        PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH
    } pc_mode_t;

    typedef enum logic [1:0] { MA_X, MA_LOAD, MA_STORE } ma_mode_t;

    typedef logic [2:0] ma_size_t; // store funct3 encoding
    localparam ma_size_t MA_SIZE_W = 3'b010;

    typedef enum logic [1:0] { WB_SRC_X, WB_SRC_ALU, WB_SRC_MEM, WB_SRC_PC4 } wb_src_t;

    typedef struct packed {
        logic         halt;
        pc_mode_t     pc_mode;
        alu_op1_sel_t alu_op1;
        alu_op2_sel_t alu_op2;
        alu_mode_t    alu_mode;
        ma_mode_t     ma_mode;
        ma_size_t     ma_size;
        wb_src_t      wb_src;
        logic         ra_used;
        logic         rb_used;
    } ctrl_word_t;

    typedef struct packed {
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_u;
        word_t imm_j;
    } imm_set_t;

    // bubble is addi x0, x0, 0
    localparam word_t     NOP_PC       = 32'h0000_0000;
    localparam word_t     NOP_IR       = 32'h0000_0013;
    localparam alu_mode_t NOP_ALU_MODE = ALU_ADD;
    localparam ma_mode_t  NOP_MA_MODE  = MA_X;
    localparam ma_size_t  NOP_MA_SIZE  = MA_SIZE_W;
    localparam wb_src_t   NOP_WB_SRC   = WB_SRC_X;

    localparam word_t PC_STEP = 32'd4;

endpackage

// File: hw/fwd_if.sv
`timescale 1ns/1ps

// write-back view of one later pipeline stage
interface fwd_if;

    id_pkg::regaddr_t addr;  // destination register
    id_pkg::word_t    data;
    logic             valid; // stage will write addr
    logic             ready; // data is final

    modport src (
        output addr,
        output data,
        output valid,
        output ready
    );

    modport dst (
        input addr,
        input data,
        input valid,
        input ready
    );

endinterface

// File: hw/id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
    input  id_pkg::word_t      ir_i,
    output id_pkg::regaddr_t   rs1_o,
    output id_pkg::regaddr_t   rs2_o,
    output id_pkg::regaddr_t   rd_o,
    output id_pkg::funct3_t    funct3_o,
    output id_pkg::ctrl_word_t ctrl_o,
    output id_pkg::imm_set_t   imm_o
);

    id_pkg::opcode_t   opcode;
    id_pkg::funct7_t   funct7;
    id_pkg::alu_mode_t mode3; // funct3 only
    id_pkg::alu_mode_t mode7; // funct7 bits included

    always_comb begin
        opcode   = ir_i[6:0];
        rd_o     = ir_i[11:7];
        funct3_o = ir_i[14:12];
        rs1_o    = ir_i[19:15];
        rs2_o    = ir_i[24:20];
        funct7   = ir_i[31:25];

        imm_o.imm_i = {{20{ir_i[31]}}, ir_i[31:20]};
        imm_o.imm_s = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
        imm_o.imm_b = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
        imm_o.imm_u = {ir_i[31:12], 12'b0};
        imm_o.imm_j = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

        mode3 = {2'b00, funct3_o};
        mode7 = {funct7[0], funct7[5], funct3_o};
    end

    always_comb begin
        // do-nothing word, overridden below
        ctrl_o.halt     = 1'b0;
        ctrl_o.pc_mode  = id_pkg::PC_NEXT;
        ctrl_o.alu_op1  = id_pkg::ALU_OP1_X;
        ctrl_o.alu_op2  = id_pkg::ALU_OP2_X;
        ctrl_o.alu_mode = id_pkg::ALU_X;
        ctrl_o.ma_mode  = id_pkg::MA_X;
        ctrl_o.ma_size  = id_pkg::MA_SIZE_W;
        ctrl_o.wb_src   = id_pkg::WB_SRC_X;
        ctrl_o.ra_used  = 1'b0;
        ctrl_o.rb_used  = 1'b0;

        case (opcode)
            id_pkg::OP: begin
                ctrl_o.alu_op1  = id_pkg::ALU_OP1_RS1;
                ctrl_o.alu_op2  = id_pkg::ALU_OP2_RS2;
                ctrl_o.alu_mode = mode7;
                ctrl_o.wb_src   = id_pkg::WB_SRC_ALU;
                ctrl_o.ra_used  = 1'b1;
                ctrl_o.rb_used  = 1'b1;
            end
            id_pkg::OP_IMM: begin
                ctrl_o.alu_op1 = id_pkg::ALU_OP1_RS1;
                ctrl_o.alu_op2 = id_pkg::ALU_OP2_IMMI;
                // srai carries its mode in funct7
                if (funct3_o == id_pkg::F3_SRL_SRA && funct7[5])
                    ctrl_o.alu_mode = mode7;
                else
                    ctrl_o.alu_mode = mode3;
                ctrl_o.wb_src  = id_pkg::WB_SRC_ALU;
                ctrl_o.ra_used = 1'b1;
            end
            id_pkg::OP_LUI: begin
                ctrl_o.alu_op1  = id_pkg::ALU_OP1_IMMU;
                ctrl_o.alu_op2  = id_pkg::ALU_OP2_RS2;
                ctrl_o.alu_mode = id_pkg::ALU_COPY1;
                ctrl_o.wb_src   = id_pkg::WB_SRC_ALU;
                ctrl_o.rb_used  = 1'b1;
            end
            id_pkg::OP_AUIPC: begin
                ctrl_o.alu_op1  = id_pkg::ALU_OP1_IMMU;
                ctrl_o.alu_op2  = id_pkg::ALU_OP2_PC;
                ctrl_o.alu_mode = id_pkg::ALU_ADD;
                ctrl_o.wb_src   = id_pkg::WB_SRC_ALU;
            end
            id_pkg::OP_JAL: begin
                ctrl_o.pc_mode = id_pkg::PC_JUMP_REL;
                ctrl_o.wb_src  = id_pkg::WB_SRC_PC4; // link register
            end
            id_pkg::OP_JALR: begin
                ctrl_o.pc_mode = id_pkg::PC_JUMP_ABS;
                ctrl_o.wb_src  = id_pkg::WB_SRC_PC4;
                ctrl_o.ra_used = 1'b1;
            end
            id_pkg::OP_BRANCH: begin
                if (funct3_o inside {id_pkg::F3_BEQ, id_pkg::F3_BNE, id_pkg::F3_BLT,
                                     id_pkg::F3_BGE, id_pkg::F3_BLTU, id_pkg::F3_BGEU}) begin
                    ctrl_o.pc_mode = id_pkg::PC_BRANCH;
                    ctrl_o.ra_used = 1'b1;
                    ctrl_o.rb_used = 1'b1;
                end else begin
                    ctrl_o.halt = 1'b1;
                end
            end
            id_pkg::OP_LOAD, id_pkg::OP_STORE: begin
                ctrl_o.alu_op1  = id_pkg::ALU_OP1_RS1;
                ctrl_o.alu_mode = id_pkg::ALU_ADD; // address = rs1 + imm
                ctrl_o.ra_used  = 1'b1;
                ctrl_o.rb_used  = 1'b1;
                if (opcode == id_pkg::OP_LOAD) begin
                    ctrl_o.alu_op2 = id_pkg::ALU_OP2_IMMI;
                    ctrl_o.ma_mode = id_pkg::MA_LOAD;
                    ctrl_o.wb_src  = id_pkg::WB_SRC_MEM;
                end else begin
                    ctrl_o.alu_op2 = id_pkg::ALU_OP2_IMMS;
                    ctrl_o.ma_mode = id_pkg::MA_STORE;
                    ctrl_o.ma_size = funct3_o;
                end
            end
            id_pkg::OP_MISC_MEM: ; // fence is a no-op here
            default: ctrl_o.halt = 1'b1; // includes SYSTEM
        endcase
    end

endmodule

// File: hw/id_regfile.sv
`timescale 1ns/1ps

module id_regfile #(
    parameter int REG_COUNT = 32
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  id_pkg::regaddr_t rd_addr1_i,
    output id_pkg::word_t    rd_data1_o,
    input  id_pkg::regaddr_t rd_addr2_i,
    output id_pkg::word_t    rd_data2_o,
    input  id_pkg::regaddr_t wr_addr_i,
    input  id_pkg::word_t    wr_data_i,
    input  logic             wr_en_i
);

    localparam int IDX_W = $clog2(REG_COUNT);

    id_pkg::word_t regs [REG_COUNT];

    // addresses beyond the file read as zero
    always_comb begin
        rd_data1_o = (32'(rd_addr1_i) < REG_COUNT) ? regs[rd_addr1_i[IDX_W-1:0]] : '0;
        rd_data2_o = (32'(rd_addr2_i) < REG_COUNT) ? regs[rd_addr2_i[IDX_W-1:0]] : '0;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wr_en_i && wr_addr_i != '0 && 32'(wr_addr_i) < REG_COUNT) begin
            regs[wr_addr_i[IDX_W-1:0]] <= wr_data_i; // x0 stays zero
        end
    end

endmodule

// File: hw/id_operand_fwd.sv
`timescale 1ns/1ps

module id_operand_fwd (
    input  id_pkg::regaddr_t rs1_i,
    input  id_pkg::regaddr_t rs2_i,
    input  logic             ra_used_i,
    input  logic             rb_used_i,
    input  id_pkg::word_t    ra_i,       // register file values
    input  id_pkg::word_t    rb_i,
    fwd_if.dst               ex_fwd,
    fwd_if.dst               ma_fwd,
    fwd_if.dst               wb_fwd,
    output id_pkg::word_t    ra_fwd_o,
    output id_pkg::word_t    rb_fwd_o,
    output logic             hazard_o
);

    // newest pending write wins
    function automatic id_pkg::word_t pick(id_pkg::regaddr_t rs, id_pkg::word_t rf_val);
        if (rs == '0)
            return rf_val;
        else if (ex_fwd.valid && ex_fwd.addr == rs)
            return ex_fwd.data;
        else if (ma_fwd.valid && ma_fwd.addr == rs)
            return ma_fwd.data;
        else if (wb_fwd.valid && wb_fwd.addr == rs)
            return wb_fwd.data;
        else
            return rf_val;
    endfunction

    // value not produced yet, e.g. load still in flight
    function automatic logic pending(id_pkg::regaddr_t rs);
        return (ex_fwd.valid && !ex_fwd.ready && ex_fwd.addr == rs)
            || (ma_fwd.valid && !ma_fwd.ready && ma_fwd.addr == rs);
    endfunction

    always_comb begin
        ra_fwd_o = pick(rs1_i, ra_i);
        rb_fwd_o = pick(rs2_i, rb_i);
        hazard_o = (ra_used_i && rs1_i != '0 && pending(rs1_i))
                || (rb_used_i && rs2_i != '0 && pending(rs2_i));
    end

endmodule

// File: hw/id_branch_unit.sv
`timescale 1ns/1ps

module id_branch_unit (
    input  id_pkg::word_t    pc_i,
    input  id_pkg::funct3_t  funct3_i,
    input  id_pkg::pc_mode_t pc_mode_i,
    input  id_pkg::imm_set_t imm_i,
    input  id_pkg::word_t    ra_i,
    input  id_pkg::word_t    rb_i,
    output id_pkg::word_t    jmp_addr_o,
    output logic             jmp_valid_o
);

    logic cond; // raw compare before inversion

    always_comb begin
        case (funct3_i[2:1])
            2'b00:   cond = (ra_i == rb_i);
            2'b10:   cond = ($signed(ra_i) < $signed(rb_i));
            2'b11:   cond = (ra_i < rb_i);
            default: cond = 1'b0; // decoder halts on these
        endcase
    end

    always_comb begin
        case (pc_mode_i)
            id_pkg::PC_JUMP_REL: begin
                jmp_valid_o = 1'b1;
                jmp_addr_o  = pc_i + imm_i.imm_j;
            end
            id_pkg::PC_JUMP_ABS: begin
                jmp_valid_o = 1'b1;
                jmp_addr_o  = ra_i + imm_i.imm_i;
            end
            id_pkg::PC_BRANCH: begin
                jmp_valid_o = cond ^ funct3_i[0]; // bne, bge, bgeu invert
                jmp_addr_o  = pc_i + imm_i.imm_b;
            end
            default: begin
                jmp_valid_o = 1'b0;
                jmp_addr_o  = '0;
            end
        endcase
    end

endmodule

// File: hw/id_output_reg.sv
`timescale 1ns/1ps

module id_output_reg (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               hazard_i,
    input  id_pkg::word_t      pc_i,
    input  id_pkg::word_t      ir_i,
    input  id_pkg::regaddr_t   rd_i,
    input  id_pkg::ctrl_word_t ctrl_i,
    input  id_pkg::imm_set_t   imm_i,
    input  id_pkg::word_t      ra_i,     // forwarded operands
    input  id_pkg::word_t      rb_i,
    output id_pkg::word_t      pc_o,
    output id_pkg::word_t      ir_o,
    output id_pkg::word_t      alu_op1_o,
    output id_pkg::word_t      alu_op2_o,
    output id_pkg::alu_mode_t  alu_mode_o,
    output id_pkg::ma_mode_t   ma_mode_o,
    output id_pkg::ma_size_t   ma_size_o,
    output id_pkg::word_t      ma_data_o,
    output id_pkg::wb_src_t    wb_src_o,
    output id_pkg::word_t      wb_data_o,
    output logic               wb_valid_o,
    output logic               halt_o
);

    id_pkg::word_t op1;
    id_pkg::word_t op2;

    always_comb begin
        case (ctrl_i.alu_op1)
            id_pkg::ALU_OP1_RS1:  op1 = ra_i;
            id_pkg::ALU_OP1_IMMU: op1 = imm_i.imm_u;
            default:              op1 = '0;
        endcase
        case (ctrl_i.alu_op2)
            id_pkg::ALU_OP2_RS2:  op2 = rb_i;
            id_pkg::ALU_OP2_IMMI: op2 = imm_i.imm_i;
            id_pkg::ALU_OP2_IMMS: op2 = imm_i.imm_s;
            id_pkg::ALU_OP2_PC:   op2 = pc_i;
            default:              op2 = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || hazard_i) begin
            // bubble
            pc_o       <= id_pkg::NOP_PC;
            ir_o       <= id_pkg::NOP_IR;
            alu_op1_o  <= '0;
            alu_op2_o  <= '0;
            alu_mode_o <= id_pkg::NOP_ALU_MODE;
            ma_mode_o  <= id_pkg::NOP_MA_MODE;
            ma_size_o  <= id_pkg::NOP_MA_SIZE;
            ma_data_o  <= '0;
            wb_src_o   <= id_pkg::NOP_WB_SRC;
            wb_data_o  <= '0;
            wb_valid_o <= 1'b0;
            halt_o     <= 1'b0;
        end else begin
            pc_o       <= pc_i;
            ir_o       <= ir_i;
            alu_op1_o  <= op1;
            alu_op2_o  <= op2;
            alu_mode_o <= ctrl_i.alu_mode;
            ma_mode_o  <= ctrl_i.ma_mode;
            ma_size_o  <= ctrl_i.ma_size;
            ma_data_o  <= rb_i;                   // store data
            wb_src_o   <= ctrl_i.wb_src;
            wb_data_o  <= pc_i + id_pkg::PC_STEP; // link address
            wb_valid_o <= (ctrl_i.wb_src != id_pkg::WB_SRC_X) && (rd_i != '0);
            halt_o     <= ctrl_i.halt;
        end
    end

endmodule

// File: hw/id_stage.sv
`timescale 1ns/1ps

module id_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::word_t     ir_i,
    input  id_pkg::regaddr_t  ex_wb_addr_i,
    input  id_pkg::word_t     ex_wb_data_i,
    input  logic              ex_wb_valid_i,
    input  logic              ex_wb_ready_i,
    input  id_pkg::regaddr_t  ma_wb_addr_i,
    input  id_pkg::word_t     ma_wb_data_i,
    input  logic              ma_wb_valid_i,
    input  logic              ma_wb_ready_i,
    input  id_pkg::regaddr_t  wb_addr_i,
    input  id_pkg::word_t     wb_data_i,
    input  logic              wb_valid_i,
    output logic              ready_async_o,
    output id_pkg::word_t     jmp_addr_async_o,
    output logic              jmp_valid_async_o,
    output id_pkg::word_t     pc_o,
    output id_pkg::word_t     ir_o,
    output id_pkg::word_t     alu_op1_o,
    output id_pkg::word_t     alu_op2_o,
    output id_pkg::alu_mode_t alu_mode_o,
    output id_pkg::ma_mode_t  ma_mode_o,
    output id_pkg::ma_size_t  ma_size_o,
    output id_pkg::word_t     ma_data_o,
    output id_pkg::wb_src_t   wb_src_o,
    output id_pkg::word_t     wb_data_o,
    output logic              wb_valid_o,
    output logic              halt_o
);

    id_pkg::regaddr_t   rs1, rs2, rd;
    id_pkg::funct3_t    funct3;
    id_pkg::ctrl_word_t ctrl;
    id_pkg::imm_set_t   imm;
    id_pkg::word_t      ra, rb, ra_fwd, rb_fwd;
    id_pkg::word_t      jmp_addr;
    logic               jmp_valid;
    logic               hazard;

    fwd_if ex_fwd ();
    fwd_if ma_fwd ();
    fwd_if wb_fwd ();

    assign ex_fwd.addr  = ex_wb_addr_i;
    assign ex_fwd.data  = ex_wb_data_i;
    assign ex_fwd.valid = ex_wb_valid_i;
    assign ex_fwd.ready = ex_wb_ready_i;
    assign ma_fwd.addr  = ma_wb_addr_i;
    assign ma_fwd.data  = ma_wb_data_i;
    assign ma_fwd.valid = ma_wb_valid_i;
    assign ma_fwd.ready = ma_wb_ready_i;
    assign wb_fwd.addr  = wb_addr_i;
    assign wb_fwd.data  = wb_data_i;
    assign wb_fwd.valid = wb_valid_i;
    assign wb_fwd.ready = 1'b1; // wb data is always final

    id_decoder u_decoder (
        .ir_i (ir_i), .rs1_o (rs1), .rs2_o (rs2), .rd_o (rd),
        .funct3_o (funct3), .ctrl_o (ctrl), .imm_o (imm)
    );

    id_regfile #(.REG_COUNT(REG_COUNT)) u_regfile (
        .clk_i (clk_i), .reset_i (reset_i),
        .rd_addr1_i (rs1), .rd_data1_o (ra),
        .rd_addr2_i (rs2), .rd_data2_o (rb),
        .wr_addr_i (wb_addr_i), .wr_data_i (wb_data_i), .wr_en_i (wb_valid_i)
    );

    id_operand_fwd u_fwd (
        .rs1_i (rs1), .rs2_i (rs2), .ra_used_i (ctrl.ra_used), .rb_used_i (ctrl.rb_used),
        .ra_i (ra), .rb_i (rb), .ex_fwd (ex_fwd), .ma_fwd (ma_fwd), .wb_fwd (wb_fwd),
        .ra_fwd_o (ra_fwd), .rb_fwd_o (rb_fwd), .hazard_o (hazard)
    );

    id_branch_unit u_branch (
        .pc_i (pc_i), .funct3_i (funct3), .pc_mode_i (ctrl.pc_mode), .imm_i (imm),
        .ra_i (ra_fwd), .rb_i (rb_fwd), .jmp_addr_o (jmp_addr), .jmp_valid_o (jmp_valid)
    );

    id_output_reg u_out (
        .clk_i (clk_i), .reset_i (reset_i), .hazard_i (hazard),
        .pc_i (pc_i), .ir_i (ir_i), .rd_i (rd), .ctrl_i (ctrl), .imm_i (imm),
        .ra_i (ra_fwd), .rb_i (rb_fwd),
        .pc_o (pc_o), .ir_o (ir_o), .alu_op1_o (alu_op1_o), .alu_op2_o (alu_op2_o),
        .alu_mode_o (alu_mode_o), .ma_mode_o (ma_mode_o), .ma_size_o (ma_size_o),
        .ma_data_o (ma_data_o), .wb_src_o (wb_src_o), .wb_data_o (wb_data_o),
        .wb_valid_o (wb_valid_o), .halt_o (halt_o)
    );

    // fetch sees no jump and a ready stage while in reset
    assign ready_async_o     = reset_i || !hazard;
    assign jmp_valid_async_o = !reset_i && jmp_valid;
    assign jmp_addr_async_o  = reset_i ? '0 : jmp_addr;

endmodule

// File: verif/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// register file mirror, written from the wb port
id_pkg::word_t     model_regs [32];

// combinational predictions for the current cycle
logic              exp_ready;
logic              exp_jv;
id_pkg::word_t     exp_ja;

// registered predictions, checked after the next edge
id_pkg::word_t     exp_pc, exp_ir, exp_op1, exp_op2, exp_ma_data, exp_wb_data;
id_pkg::alu_mode_t exp_mode;
id_pkg::ma_mode_t  exp_ma_mode;
id_pkg::ma_size_t  exp_ma_size;
id_pkg::wb_src_t   exp_wb_src;
logic              exp_wb_valid;
logic              exp_halt;

// newest pending write wins, x0 is always zero
function automatic id_pkg::word_t fwd_value(id_pkg::regaddr_t rs);
    if (rs == 5'd0)
        return 32'd0;
    if (ex_wb_valid_i && ex_wb_addr_i == rs)
        return ex_wb_data_i;
    if (ma_wb_valid_i && ma_wb_addr_i == rs)
        return ma_wb_data_i;
    if (wb_valid_i && wb_addr_i == rs)
        return wb_data_i;
    return model_regs[rs];
endfunction

// source still being produced by ex or ma
function automatic logic not_ready(id_pkg::regaddr_t rs);
    return rs != 5'd0
        && ((ex_wb_valid_i && !ex_wb_ready_i && ex_wb_addr_i == rs)
         || (ma_wb_valid_i && !ma_wb_ready_i && ma_wb_addr_i == rs));
endfunction

task automatic predict_bubble();
    exp_pc       = 32'd0;
    exp_ir       = 32'h0000_0013; // addi x0, x0, 0
    exp_op1      = 32'd0;
    exp_op2      = 32'd0;
    exp_mode     = 5'd0;
    exp_ma_mode  = id_pkg::MA_X;
    exp_ma_size  = 3'b010; // word
    exp_ma_data  = 32'd0;
    exp_wb_src   = id_pkg::WB_SRC_X;
    exp_wb_data  = 32'd0;
    exp_wb_valid = 1'b0;
    exp_halt     = 1'b0;
endtask

task automatic predict_reset();
    predict_bubble();
    exp_ready = 1'b1;
    exp_jv    = 1'b0;
    exp_ja    = 32'd0;
endtask

task automatic predict_decode();
    id_pkg::regaddr_t rs1;
    id_pkg::regaddr_t rs2;
    id_pkg::regaddr_t rd;
    logic [2:0]       f3;
    logic [6:0]       f7;
    id_pkg::word_t    a;
    id_pkg::word_t    b;
    id_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
    logic             use_a;
    logic             use_b;
    logic             taken;

    rs1   = ir_i[19:15];
    rs2   = ir_i[24:20];
    rd    = ir_i[11:7];
    f3    = ir_i[14:12];
    f7    = ir_i[31:25];
    imm_i = $signed(ir_i) >>> 20;
    imm_s = {{21{ir_i[31]}}, ir_i[30:25], ir_i[11:7]};
    imm_b = {{20{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    imm_u = {ir_i[31:12], 12'h000};
    imm_j = {{12{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
    a     = fwd_value(rs1);
    b     = fwd_value(rs2);

    predict_bubble();
    use_a  = 1'b0;
    use_b  = 1'b0;
    exp_jv = 1'b0;
    exp_ja = 32'd0;
    case (ir_i[6:0])
        id_pkg::OP: begin
            exp_op1    = a;
            exp_op2    = b;
            exp_mode   = {f7[0], f7[5], f3};
            exp_wb_src = id_pkg::WB_SRC_ALU;
            use_a      = 1'b1;
            use_b      = 1'b1;
        end
        id_pkg::OP_IMM: begin
            exp_op1    = a;
            exp_op2    = imm_i;
            exp_mode   = (f3 == 3'b101 && f7[5]) ? {f7[0], f7[5], f3} : {2'b00, f3};
            exp_wb_src = id_pkg::WB_SRC_ALU;
            use_a      = 1'b1;
        end
        id_pkg::OP_LUI: begin
            exp_op1    = imm_u;
            exp_op2    = b;
            exp_mode   = 5'b11111; // copy operand 1
            exp_wb_src = id_pkg::WB_SRC_ALU;
            use_b      = 1'b1;
        end
        id_pkg::OP_AUIPC: begin
            exp_op1    = imm_u;
            exp_op2    = pc_i;
            exp_wb_src = id_pkg::WB_SRC_ALU;
        end
        id_pkg::OP_JAL: begin
            exp_jv     = 1'b1;
            exp_ja     = pc_i + imm_j;
            exp_wb_src = id_pkg::WB_SRC_PC4;
        end
        id_pkg::OP_JALR: begin
            exp_jv     = 1'b1;
            exp_ja     = a + imm_i;
            exp_wb_src = id_pkg::WB_SRC_PC4;
            use_a      = 1'b1;
        end
        id_pkg::OP_BRANCH: begin
            if (f3[2:1] == 2'b01) begin
                exp_halt = 1'b1; // no such branch
            end else begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                exp_jv = taken;
                exp_ja = pc_i + imm_b;
                use_a  = 1'b1;
                use_b  = 1'b1;
            end
        end
        id_pkg::OP_LOAD: begin
            exp_op1     = a;
            exp_op2     = imm_i;
            exp_ma_mode = id_pkg::MA_LOAD;
            exp_wb_src  = id_pkg::WB_SRC_MEM;
            use_a       = 1'b1;
            use_b       = 1'b1;
        end
        id_pkg::OP_STORE: begin
            exp_op1     = a;
            exp_op2     = imm_s;
            exp_ma_mode = id_pkg::MA_STORE;
            exp_ma_size = f3;
            use_a       = 1'b1;
            use_b       = 1'b1;
        end
        id_pkg::OP_MISC_MEM: ; // fence does nothing
        default: exp_halt = 1'b1;
    endcase

    exp_ready    = !((use_a && not_ready(rs1)) || (use_b && not_ready(rs2)));
    exp_pc       = pc_i;
    exp_ir       = ir_i;
    exp_ma_data  = b;
    exp_wb_data  = pc_i + 32'd4;
    exp_wb_valid = (exp_wb_src != id_pkg::WB_SRC_X) && (rd != 5'd0);
    if (!exp_ready)
        predict_bubble(); // load-use stall
endtask

task automatic update_mirror();
    if (!reset_i && wb_valid_i && wb_addr_i != 5'd0)
        model_regs[wb_addr_i] = wb_data_i;
endtask

`endif

// File: verif/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES   = 2000;
    localparam int CYCLE_LIMIT  = 2 * (NUM_CYCLES + RESET_CYCLES);

    logic              clk_i;
    logic              reset_i;
    id_pkg::word_t     pc_i;
    id_pkg::word_t     ir_i;
    id_pkg::regaddr_t  ex_wb_addr_i;
    id_pkg::word_t     ex_wb_data_i;
    logic              ex_wb_valid_i;
    logic              ex_wb_ready_i;
    id_pkg::regaddr_t  ma_wb_addr_i;
    id_pkg::word_t     ma_wb_data_i;
    logic              ma_wb_valid_i;
    logic              ma_wb_ready_i;
    id_pkg::regaddr_t  wb_addr_i;
    id_pkg::word_t     wb_data_i;
    logic              wb_valid_i;
    logic              ready_async_o;
    id_pkg::word_t     jmp_addr_async_o;
    logic              jmp_valid_async_o;
    id_pkg::word_t     pc_o, ir_o, alu_op1_o, alu_op2_o, ma_data_o, wb_data_o;
    id_pkg::alu_mode_t alu_mode_o;
    id_pkg::ma_mode_t  ma_mode_o;
    id_pkg::ma_size_t  ma_size_o;
    id_pkg::wb_src_t   wb_src_o;
    logic              wb_valid_o;
    logic              halt_o;

    id_pkg::word_t     lcg_state = 32'd49813;
    int unsigned       cycle_count = 0;
    logic              hold;

    `include "tb_model.svh"

    id_stage #(.REG_COUNT(32)) DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            report_failure("timeout: the cycle limit ran out before the stimulus finished");
    end

    task automatic report_failure(string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic id_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]}; // better bits go low
    endfunction

    function automatic logic chance(int unsigned pct);
        return (lcg_next() % 100) < pct;
    endfunction

    // x0..x7 only, so fields collide often
    function automatic id_pkg::regaddr_t small_reg();
        id_pkg::word_t r;
        r = lcg_next();
        return {2'b00, r[2:0]};
    endfunction

    function automatic id_pkg::word_t random_instr();
        id_pkg::word_t ir;
        id_pkg::word_t pick;
        ir        = lcg_next();
        ir[11:7]  = small_reg();
        ir[19:15] = small_reg();
        ir[24:20] = small_reg();
        pick      = lcg_next() % 20;
        case (pick)
            0, 1, 2: begin
                ir[6:0] = id_pkg::OP;
                pick    = lcg_next() % 3;
                ir[31:25] = (pick == 0) ? 7'h00 : (pick == 1) ? 7'h20 : 7'h01;
            end
            3, 4, 5:    ir[6:0] = id_pkg::OP_IMM;
            6:          ir[6:0] = id_pkg::OP_LUI;
            7:          ir[6:0] = id_pkg::OP_AUIPC;
            8:          ir[6:0] = id_pkg::OP_JAL;
            9:          ir[6:0] = id_pkg::OP_JALR;
            10, 11, 12: ir[6:0] = id_pkg::OP_BRANCH; // funct3 010/011 are illegal
            13, 14:     ir[6:0] = id_pkg::OP_LOAD;
            15, 16:     ir[6:0] = id_pkg::OP_STORE;
            17:         ir[6:0] = id_pkg::OP_MISC_MEM;
            18:         ir[6:0] = 7'b1110011; // system
            default: ; // random opcode
        endcase
        return ir;
    endfunction

    task automatic drive_inputs(input logic keep_instr);
        if (!keep_instr) begin
            pc_i = lcg_next() & ~32'h3;
            ir_i = random_instr();
        end
        ex_wb_addr_i  = small_reg();
        ex_wb_data_i  = lcg_next();
        ex_wb_valid_i = chance(50);
        ex_wb_ready_i = chance(70);
        ma_wb_addr_i  = small_reg();
        ma_wb_data_i  = lcg_next();
        ma_wb_valid_i = chance(50);
        ma_wb_ready_i = chance(70);
        wb_addr_i     = small_reg();
        wb_data_i     = lcg_next();
        wb_valid_i    = chance(60);
    endtask

    task automatic check_word(string what, id_pkg::word_t got, id_pkg::word_t exp);
        if (got !== exp)
            report_failure($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp)
            report_failure($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_alu_mode(string what, id_pkg::alu_mode_t got, id_pkg::alu_mode_t exp);
        if (got !== exp)
            report_failure($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_ma(id_pkg::ma_mode_t got_mode, id_pkg::ma_mode_t exp_mode,
                            id_pkg::ma_size_t got_size, id_pkg::ma_size_t exp_size);
        if (got_mode !== exp_mode || got_size !== exp_size)
            report_failure($sformatf("FAILED at %0t: ma_mode/ma_size is %s/%b, expected %s/%b",
                                     $time, got_mode.name(), got_size, exp_mode.name(), exp_size));
    endtask

    task automatic check_wb_src(string what, id_pkg::wb_src_t got, id_pkg::wb_src_t exp);
        if (got !== exp)
            report_failure($sformatf("FAILED at %0t: %s is %s, expected %s", $time, what,
                                     got.name(), exp.name()));
    endtask

    task automatic check_registered();
        check_word("pc_o", pc_o, exp_pc);
        check_word("ir_o", ir_o, exp_ir);
        check_word("alu_op1_o", alu_op1_o, exp_op1);
        check_word("alu_op2_o", alu_op2_o, exp_op2);
        check_alu_mode("alu_mode_o", alu_mode_o, exp_mode);
        check_ma(ma_mode_o, exp_ma_mode, ma_size_o, exp_ma_size);
        check_word("ma_data_o", ma_data_o, exp_ma_data);
        check_wb_src("wb_src_o", wb_src_o, exp_wb_src);
        check_word("wb_data_o", wb_data_o, exp_wb_data);
        check_bit("wb_valid_o", wb_valid_o, exp_wb_valid);
        check_bit("halt_o", halt_o, exp_halt);
    endtask

    task automatic check_async();
        check_bit("ready_async_o", ready_async_o, exp_ready);
        check_bit("jmp_valid_async_o", jmp_valid_async_o, exp_jv);
        check_word("jmp_addr_async_o", jmp_addr_async_o, exp_ja);
    endtask

    initial begin
        reset_i = 1'b1;
        pc_i    = 32'd0;
        ir_i    = 32'h0000_0013;
        ex_wb_addr_i  = 5'd0;
        ex_wb_data_i  = 32'd0;
        ex_wb_valid_i = 1'b0;
        ex_wb_ready_i = 1'b1;
        ma_wb_addr_i  = 5'd0;
        ma_wb_data_i  = 32'd0;
        ma_wb_valid_i = 1'b0;
        ma_wb_ready_i = 1'b1;
        wb_addr_i     = 5'd0;
        wb_data_i     = 32'd0;
        wb_valid_i    = 1'b0;
        hold          = 1'b0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'd0;
        predict_reset();

        for (int cyc = 0; cyc < RESET_CYCLES + NUM_CYCLES; cyc++) begin
            @(posedge clk_i);
            #1;
            check_registered(); // outputs of the previous cycle
            if (cyc == RESET_CYCLES - 1)
                reset_i = 1'b0;
            drive_inputs(hold);
            #58;
            if (reset_i)
                predict_reset();
            else
                predict_decode();
            check_async();
            hold = !exp_ready; // fetch holds pc and ir while stalled
            update_mirror();
        end
        @(posedge clk_i);
        #1;
        check_registered();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: build.f
+incdir+verif
hw/id_pkg.sv
hw/fwd_if.sv
hw/id_decoder.sv
hw/id_regfile.sv
hw/id_operand_fwd.sv
hw/id_branch_unit.sv
hw/id_output_reg.sv
hw/id_stage.sv
verif/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_id_stage
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
